/* hdl/dcache_ram_config.svh */
`ifndef DCACHE_RAM_CONFIG_SVH
`define DCACHE_RAM_CONFIG_SVH

// ========================================
// cache organisation
// ========================================
`define DCACHE_WAYS        4
`define DCACHE_TAG_BANKS   2
`define DCACHE_DATA_BANKS  4

// ========================================
// field widths, depths come from the idx widths
// ========================================
`define DCACHE_TAG_W       30
// shrunk index for quick simulation
`define DCACHE_TAG_IDX_W   8
`define DCACHE_DATA_W      64
`define DCACHE_DATA_IDX_W  10
`define DCACHE_DIRTY_W     8

`endif

/* hdl/dcache_ram_pkg.sv */
`include "dcache_ram_config.svh"

package dcache_ram_pkg;

  // tag side
  typedef logic [`DCACHE_TAG_W-1:0]                tag_t;
  typedef logic [`DCACHE_TAG_IDX_W-1:0]            tag_idx_t;
  typedef logic [`DCACHE_WAYS-1:0]                 way_mask_t;
  // all ways of one set, way 0 in the low bits
  typedef logic [`DCACHE_WAYS*`DCACHE_TAG_W-1:0]   tag_set_t;
  typedef logic [`DCACHE_TAG_BANKS-1:0]            tag_bank_sel_t;

  // data side
  typedef logic [`DCACHE_DATA_W-1:0]               data_t;
  typedef logic [`DCACHE_DATA_IDX_W-1:0]           data_idx_t;
  // active low, bit i covers byte i
  typedef logic [`DCACHE_DATA_W/8-1:0]             byte_wen_t;

  // dirty vector, also its active-low bit write enable
  typedef logic [`DCACHE_DIRTY_W-1:0]              dirty_t;

  // one tag access, steered to banks by sel
  typedef struct packed {
    logic          req;   // active high
    logic          wen;   // active low
    tag_bank_sel_t sel;
    way_mask_t     way;
    tag_idx_t      idx;
    tag_t          din;
  } tag_req_t;

  // per data bank strobe and write data
  typedef struct packed {
    logic  cen;           // active low
    data_t din;
  } data_req_t;

  typedef struct packed {
    logic      cen;       // active low
    dirty_t    wen;       // active low per bit
    data_idx_t idx;
    dirty_t    din;
  } dirty_req_t;

endpackage

/* hdl/dcache_tag_bank.sv */
`timescale 1ns/1ns

`include "dcache_ram_config.svh"

module dcache_tag_bank #(
  // own bank number, picks the select bit
  parameter int BANK = 0
) (
  input  logic                     forever_cpuclk,
  input  logic                     rst_n,
  input  dcache_ram_pkg::tag_req_t req,
  output dcache_ram_pkg::tag_set_t dout
);
  import dcache_ram_pkg::*;

  localparam int DEPTH = 1 << `DCACHE_TAG_IDX_W;

  // ========================================
  // storage and access decode
  // ========================================
  tag_set_t mem [DEPTH];

  logic bank_en;
  logic rd;
  logic wr;

  // bank takes part only when requested and selected
  assign bank_en = req.req && req.sel[BANK];
  // wen high means read
  assign rd      = bank_en && req.wen;
  assign wr      = bank_en && !req.wen;

  // same tag broadcast to every way
  // only ways named in req.way get it
  always_ff @(posedge forever_cpuclk) begin
    if (wr) begin
      for (int w = 0; w < `DCACHE_WAYS; w++) begin
        if (req.way[w]) begin
          mem[req.idx][w*`DCACHE_TAG_W +: `DCACHE_TAG_W] <= req.din;
        end
      end
    end
  end

  // ========================================
  // read port, one cycle latency
  // ========================================
  // holds until the next read of this bank
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (rd) begin
      dout <= mem[req.idx];
    end
  end

  // a write with no way picked would be lost silently
  a_write_has_way: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    wr |-> (req.way != '0)
  ) else $error("tag bank %0d write with empty way vector", BANK);

endmodule

/* hdl/dcache_data_bank.sv */
`timescale 1ns/1ns

`include "dcache_ram_config.svh"

module dcache_data_bank (
  input  logic                      forever_cpuclk,
  input  logic                      rst_n,
  input  dcache_ram_pkg::data_req_t req,
  input  dcache_ram_pkg::byte_wen_t wen,
  input  dcache_ram_pkg::data_idx_t idx,
  output dcache_ram_pkg::data_t     dout
);
  import dcache_ram_pkg::*;

  localparam int DEPTH = 1 << `DCACHE_DATA_IDX_W;
  localparam int BYTES = `DCACHE_DATA_W / 8;

  data_t mem [DEPTH];

  // per bit write enable, still active low
  data_t bit_wen_n;
  logic  rd;
  logic  wr;

  always_comb begin
    for (int i = 0; i < BYTES; i++) begin
      bit_wen_n[i*8 +: 8] = {8{wen[i]}};
    end
  end

  // all byte enables high means read
  assign rd = !req.cen && (&wen);
  assign wr = !req.cen && !(&wen);

  // ========================================
  // byte masked write
  // ========================================
  // disabled bytes keep old contents
  always_ff @(posedge forever_cpuclk) begin
    if (wr) begin
      mem[idx] <= (mem[idx] & bit_wen_n) | (req.din & ~bit_wen_n);
    end
  end

  // registered read, held between reads
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (rd) begin
      dout <= mem[idx];
    end
  end

  // index comes from the shared even/odd group at top
  a_idx_known: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    !req.cen |-> !$isunknown(idx)
  ) else $error("data bank accessed with unknown index");

endmodule

/* hdl/dcache_dirty_array.sv */
`timescale 1ns/1ns

`include "dcache_ram_config.svh"

module dcache_dirty_array (
  input  logic                       forever_cpuclk,
  input  logic                       rst_n,
  input  dcache_ram_pkg::dirty_req_t req,
  output dcache_ram_pkg::dirty_t     dout
);
  import dcache_ram_pkg::*;

  // indexed like the data banks
  localparam int DEPTH = 1 << `DCACHE_DATA_IDX_W;

  dirty_t mem [DEPTH];

  logic rd;
  logic wr;

  // no bit enabled means read
  assign rd = !req.cen && (&req.wen);
  assign wr = !req.cen && !(&req.wen);

  // bits with wen low take din
  always_ff @(posedge forever_cpuclk) begin
    if (wr) begin
      mem[req.idx] <= (mem[req.idx] & req.wen) | (req.din & ~req.wen);
    end
  end

  // read data valid next cycle
  always_ff @(posedge forever_cpuclk or negedge rst_n) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (rd) begin
      dout <= mem[req.idx];
    end
  end

  a_idx_known: assert property (
    @(posedge forever_cpuclk) disable iff (!rst_n)
    !req.cen |-> !$isunknown(req.idx)
  ) else $error("dirty array accessed with unknown index");

endmodule

/* hdl/dcache_ram_top.sv */
`timescale 1ns/1ns

`include "dcache_ram_config.svh"

module dcache_ram_top (
  input  logic                                               forever_cpuclk,
  input  logic                                               rst_n,
  // tag side
  input  dcache_ram_pkg::tag_req_t                           tag_req,
  output dcache_ram_pkg::tag_set_t  [`DCACHE_TAG_BANKS-1:0]  tag_dout,
  // data side
  input  dcache_ram_pkg::data_req_t [`DCACHE_DATA_BANKS-1:0] data_req,
  input  dcache_ram_pkg::byte_wen_t                          data_wen,
  input  dcache_ram_pkg::data_idx_t                          data02_idx,
  input  dcache_ram_pkg::data_idx_t                          data13_idx,
  output dcache_ram_pkg::data_t     [`DCACHE_DATA_BANKS-1:0] data_dout,
  // dirty side
  input  dcache_ram_pkg::dirty_req_t                         dirty_req,
  output dcache_ram_pkg::dirty_t                             dirty_dout
);
  import dcache_ram_pkg::*;

  // ========================================
  // tag banks
  // ========================================
  // whole request to every bank
  // each bank checks its own select bit
  for (genvar t = 0; t < `DCACHE_TAG_BANKS; t++) begin : g_tag
    dcache_tag_bank #(
      .BANK (t)
    ) tag_bank_i (
      .forever_cpuclk (forever_cpuclk),
      .rst_n          (rst_n),
      .req            (tag_req),
      .dout           (tag_dout[t])
    );
  end

  // ========================================
  // data banks
  // ========================================
  // even banks on data02_idx, odd banks on data13_idx
  // byte enables shared by all banks
  for (genvar b = 0; b < `DCACHE_DATA_BANKS; b++) begin : g_data
    data_idx_t bank_idx;

    assign bank_idx = (b % 2 == 0) ? data02_idx : data13_idx;

    dcache_data_bank data_bank_i (
      .forever_cpuclk (forever_cpuclk),
      .rst_n          (rst_n),
      .req            (data_req[b]),
      .wen            (data_wen),
      .idx            (bank_idx),
      .dout           (data_dout[b])
    );
  end

  // ========================================
  // dirty array
  // ========================================
  // single instance
  for (genvar d = 0; d < 1; d++) begin : g_dirty
    dcache_dirty_array dirty_array_i (
      .forever_cpuclk (forever_cpuclk),
      .rst_n          (rst_n),
      .req            (dirty_req),
      .dout           (dirty_dout)
    );
  end

endmodule

/* dv/dcache_ram_tb.sv */
`timescale 1ns/1ns

`include "dcache_ram_config.svh"

module dcache_ram_tb;
  import dcache_ram_pkg::*;

  localparam int CLK_PERIOD = 40;
  // 8 tag_way_write + 2 broadcast + 3 byte mask + 5 index groups + 4 dirty
  localparam int TOTAL_ACCESSES = 22;
  localparam int TBANKS = `DCACHE_TAG_BANKS;
  localparam int DBANKS = `DCACHE_DATA_BANKS;

  logic                     forever_cpuclk;
  logic                     rst_n;
  tag_req_t                 tag_req;
  tag_set_t  [TBANKS-1:0]   tag_dout;
  data_req_t [DBANKS-1:0]   data_req;
  byte_wen_t                data_wen;
  data_idx_t                data02_idx;
  data_idx_t                data13_idx;
  data_t     [DBANKS-1:0]   data_dout;
  dirty_req_t               dirty_req;
  dirty_t                   dirty_dout;

  // reference contents and last read values
  tag_set_t  tag_model [TBANKS][1 << `DCACHE_TAG_IDX_W];
  data_t     data_model [DBANKS][1 << `DCACHE_DATA_IDX_W];
  dirty_t    dirty_model [1 << `DCACHE_DATA_IDX_W];
  tag_set_t  [TBANKS-1:0]   exp_tag;
  data_t     [DBANKS-1:0]   exp_data;
  dirty_t                   exp_dirty;

  logic [31:0] lfsr;
  string       test_name;

  dcache_ram_top dcache_ram_top_i (
    .forever_cpuclk (forever_cpuclk),
    .rst_n          (rst_n),
    .tag_req        (tag_req),
    .tag_dout       (tag_dout),
    .data_req       (data_req),
    .data_wen       (data_wen),
    .data02_idx     (data02_idx),
    .data13_idx     (data13_idx),
    .data_dout      (data_dout),
    .dirty_req      (dirty_req),
    .dirty_dout     (dirty_dout)
  );

  always #(CLK_PERIOD / 2) forever_cpuclk = ~forever_cpuclk;

  // ========================================
  // helpers
  // ========================================
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  task automatic check(input string what, input logic [127:0] expected,
                       input logic [127:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // every output against its last read value
  task automatic check_outputs();
    for (int b = 0; b < TBANKS; b++) begin
      check($sformatf("tag_dout[%0d]", b), 128'(exp_tag[b]), 128'(tag_dout[b]));
    end
    for (int b = 0; b < DBANKS; b++) begin
      check($sformatf("data_dout[%0d]", b), 128'(exp_data[b]), 128'(data_dout[b]));
    end
    check("dirty_dout", 128'(exp_dirty), 128'(dirty_dout));
  endtask

  task automatic idle_inputs();
    tag_req = '0;
    for (int b = 0; b < DBANKS; b++) begin
      data_req[b].cen = 1'b1;
      data_req[b].din = '0;
    end
    data_wen   = '1;
    data02_idx = '0;
    data13_idx = '0;
    dirty_req  = '{cen: 1'b1, wen: '1, idx: '0, din: '0};
  endtask

  // ========================================
  // one-cycle accesses entered at a falling edge
  // ========================================
  task automatic tag_access(input tag_bank_sel_t sel, input logic wen, input way_mask_t way,
                            input tag_idx_t idx, input tag_t din);
    tag_req = '{req: 1'b1, wen: wen, sel: sel, way: way, idx: idx, din: din};
    @(negedge forever_cpuclk);
    for (int b = 0; b < TBANKS; b++) begin
      if (sel[b] && wen) begin
        exp_tag[b] = tag_model[b][idx];
      end else if (sel[b]) begin
        // same tag into every picked way
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
          if (way[w]) begin
            tag_model[b][idx][w*`DCACHE_TAG_W +: `DCACHE_TAG_W] = din;
          end
        end
      end
    end
    idle_inputs();
    check_outputs();
  endtask

  // cen_n bit b enables bank b when low
  task automatic data_access(input logic [DBANKS-1:0] cen_n, input byte_wen_t wen,
                             input data_idx_t i02, input data_idx_t i13,
                             input data_t [DBANKS-1:0] din);
    data_idx_t idx;
    for (int b = 0; b < DBANKS; b++) begin
      data_req[b].cen = cen_n[b];
      data_req[b].din = din[b];
    end
    data_wen   = wen;
    data02_idx = i02;
    data13_idx = i13;
    @(negedge forever_cpuclk);
    for (int b = 0; b < DBANKS; b++) begin
      // even banks follow data02_idx and odd ones data13_idx
      idx = (b % 2 == 0) ? i02 : i13;
      if (!cen_n[b] && (&wen)) begin
        exp_data[b] = data_model[b][idx];
      end else if (!cen_n[b]) begin
        for (int k = 0; k < `DCACHE_DATA_W / 8; k++) begin
          if (!wen[k]) begin
            data_model[b][idx][k*8 +: 8] = din[b][k*8 +: 8];
          end
        end
      end
    end
    idle_inputs();
    check_outputs();
  endtask

  task automatic dirty_access(input dirty_t wen, input data_idx_t idx, input dirty_t din);
    dirty_req = '{cen: 1'b0, wen: wen, idx: idx, din: din};
    @(negedge forever_cpuclk);
    if (&wen) begin
      exp_dirty = dirty_model[idx];
    end else begin
      for (int k = 0; k < `DCACHE_DIRTY_W; k++) begin
        if (!wen[k]) begin
          dirty_model[idx][k] = din[k];
        end
      end
    end
    idle_inputs();
    check_outputs();
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic reset_outputs();
    test_name = "reset_outputs";
    exp_tag   = '0;
    exp_data  = '0;
    exp_dirty = '0;
    check_outputs();
  endtask

  task automatic tag_way_write();
    tag_idx_t idx;
    tag_t     t [`DCACHE_WAYS];
    test_name = "tag_way_write";
    idx = tag_idx_t'(rand_bits(`DCACHE_TAG_IDX_W));
    // known contents in bank 1 first
    tag_access(2'b10, 1'b0, '1, idx, tag_t'(rand_bits(`DCACHE_TAG_W)));
    tag_access(2'b10, 1'b1, '0, idx, '0);
    for (int w = 0; w < `DCACHE_WAYS; w++) begin
      t[w] = tag_t'(rand_bits(`DCACHE_TAG_W));
      tag_access(2'b01, 1'b0, way_mask_t'(1 << w), idx, t[w]);
    end
    tag_access(2'b01, 1'b1, '0, idx, '0);
    check("bank 0 ways", 128'({t[3], t[2], t[1], t[0]}), 128'(tag_dout[0]));
    // bank 1 untouched
    tag_access(2'b10, 1'b1, '0, idx, '0);
  endtask

  task automatic tag_broadcast_both_banks();
    tag_idx_t idx;
    tag_t     t;
    test_name = "tag_broadcast_both_banks";
    idx = tag_idx_t'(rand_bits(`DCACHE_TAG_IDX_W));
    t   = tag_t'(rand_bits(`DCACHE_TAG_W));
    tag_access(2'b11, 1'b0, '1, idx, t);
    tag_access(2'b11, 1'b1, '0, idx, '0);
    for (int b = 0; b < TBANKS; b++) begin
      check($sformatf("bank %0d all ways", b), 128'({4{t}}), 128'(tag_dout[b]));
    end
  endtask

  task automatic data_byte_mask();
    data_idx_t           idx;
    data_t [DBANKS-1:0]  w1;
    data_t [DBANKS-1:0]  w2;
    // bytes 0 2 5 7 enabled by wen 8'h5a
    data_t               keep;
    test_name = "data_byte_mask";
    keep = 64'hff00_ff00_00ff_00ff;
    idx = data_idx_t'(rand_bits(`DCACHE_DATA_IDX_W));
    w1 = '0;
    w2 = '0;
    w1[0] = rand_bits(`DCACHE_DATA_W);
    w2[0] = rand_bits(`DCACHE_DATA_W);
    data_access(4'b1110, 8'h00, idx, '0, w1);
    data_access(4'b1110, 8'h5a, idx, '0, w2);
    data_access(4'b1110, 8'hff, idx, '0, '0);
    check("merged word", 128'((w2[0] & keep) | (w1[0] & ~keep)), 128'(data_dout[0]));
  endtask

  task automatic data_index_groups();
    data_idx_t           a;
    data_idx_t           b;
    data_idx_t           d;
    data_t [DBANKS-1:0]  p;
    data_t [DBANKS-1:0]  q;
    data_t [DBANKS-1:0]  w;
    test_name = "data_index_groups";
    a = data_idx_t'(rand_bits(`DCACHE_DATA_IDX_W));
    b = a ^ 10'h155;
    d = a ^ 10'h2aa;
    for (int k = 0; k < DBANKS; k++) begin
      p[k] = rand_bits(`DCACHE_DATA_W);
      q[k] = rand_bits(`DCACHE_DATA_W);
      w[k] = rand_bits(`DCACHE_DATA_W);
    end
    // odd banks at a and even banks at b
    data_access(4'b0101, 8'h00, d, a, p);
    data_access(4'b1010, 8'h00, b, d, q);
    data_access(4'b0000, 8'h00, a, b, w);
    data_access(4'b0000, 8'hff, a, b, '0);
    // swapped indices expose the prefill
    data_access(4'b0000, 8'hff, b, a, '0);
    for (int k = 0; k < DBANKS; k++) begin
      check($sformatf("bank %0d swapped read", k), 128'((k % 2 == 0) ? q[k] : p[k]),
            128'(data_dout[k]));
    end
  endtask

  task automatic dirty_bits_and_hold();
    data_idx_t idx;
    dirty_t    v;
    test_name = "dirty_bits_and_hold";
    idx = data_idx_t'(rand_bits(`DCACHE_DATA_IDX_W));
    // bits 2 and 6 start clear so the single-bit sets show
    v   = dirty_t'(rand_bits(`DCACHE_DIRTY_W)) & ~8'h44;
    dirty_access(8'h00, idx, v);
    dirty_access(~8'h04, idx, 8'hff);
    dirty_access(~8'h40, idx, 8'hff);
    dirty_access(8'hff, idx, 8'h00);
    check("merged vector", 128'(v | 8'h44), 128'(dirty_dout));
    // nothing requested so outputs hold
    repeat (6) begin
      @(negedge forever_cpuclk);
      check_outputs();
    end
  endtask

  // ========================================
  // sequence and watchdog
  // ========================================
  initial begin
    forever_cpuclk = 1'b0;
    rst_n = 1'b0;
    lfsr  = 32'h5b89c2d9;
    idle_inputs();
    repeat (4) @(negedge forever_cpuclk);
    rst_n = 1'b1;
    reset_outputs();
    tag_way_write();
    tag_broadcast_both_banks();
    data_byte_mask();
    data_index_groups();
    dirty_bits_and_hold();
    $display("Everything OK");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * (TOTAL_ACCESSES + 50));
    $display("timeout: the tests did not finish in time");
    $display("Something failed");
    $fatal(1);
  end

endmodule

/* dcache_ram.f */
+incdir+hdl
hdl/dcache_ram_pkg.sv
hdl/dcache_tag_bank.sv
hdl/dcache_data_bank.sv
hdl/dcache_dirty_array.sv
hdl/dcache_ram_top.sv
dv/dcache_ram_tb.sv

/* Makefile */
TOP  := dcache_ram_tb
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): dcache_ram.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns -f dcache_ram.f --top-module $(TOP)

run: $(BIN)
	./$(BIN) | awk '{ print } /^Everything OK$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
